// File: hdl/conv1_macros.svh
`ifndef CONV1_MACROS_SVH
`define CONV1_MACROS_SVH

`default_nettype none

// image geometry
`define CONV1_IMG_WIDTH      28
`define CONV1_IMG_HEIGHT     28

// filter geometry
`define CONV1_FILTER_SIZE    5
`define CONV1_TAPS           25   // filter size squared
`define CONV1_CHANNELS       3

// datapath widths
`define CONV1_PIXEL_BITS     8
`define CONV1_COEF_BITS      8
`define CONV1_ACC_BITS       20
`define CONV1_OUT_BITS       12
`define CONV1_FRAC_SHIFT     8    // sum bits 19..8 kept

// register map, word indices
`define CONV1_AXI_ADDR_BITS  10
`define CONV1_BIAS_BASE      80

`default_nettype wire

`endif

// File: hdl/conv1_pkg.sv
`include "conv1_macros.svh"
`default_nettype none

package conv1_pkg;

   // pixels are unsigned, coefficients signed
   typedef logic        [`CONV1_PIXEL_BITS-1:0] pixel_t;
   typedef logic signed [`CONV1_COEF_BITS-1:0]  coef_t;

   // one kernel, tap 0 at the top-left, row-major
   typedef coef_t kernel_t [0:`CONV1_TAPS-1];

   // 5x5 pixel window in the same tap order as kernel_t
   typedef pixel_t window_t [0:`CONV1_TAPS-1];

   typedef logic signed [`CONV1_OUT_BITS-1:0] conv_t;
   typedef logic signed [`CONV1_ACC_BITS-1:0] acc_t;

   typedef coef_t bias_t [0:`CONV1_CHANNELS-1];   // one per channel

   typedef enum logic {
      FILL_ROWS,   // first four rows of a frame
      SLIDE        // window positions available
   } fill_state_e;

   typedef enum logic {
      WR_IDLE,
      WR_RESP
   } axi_wr_state_e;

endpackage

`default_nettype wire

// File: hdl/coef_if.sv
`timescale 1ns/100ps
`default_nettype none

// static coefficient bus, no handshake
interface coef_if;

   conv1_pkg::kernel_t kernel_0;
   conv1_pkg::kernel_t kernel_1;
   conv1_pkg::kernel_t kernel_2;
   conv1_pkg::bias_t   bias;

   modport regs (
      output kernel_0,
      output kernel_1,
      output kernel_2,
      output bias
   );

   modport mac (
      input kernel_0,
      input kernel_1,
      input kernel_2,
      input bias
   );

endinterface

`default_nettype wire

// File: hdl/coef_regs.sv
`timescale 1ns/100ps
`include "conv1_macros.svh"
`default_nettype none

module coef_regs (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [`CONV1_AXI_ADDR_BITS-1:0] s_axi_awaddr,
   input  logic                            s_axi_awvalid,
   output logic                            s_axi_awready,
   input  logic [31:0]                     s_axi_wdata,
   input  logic [3:0]                      s_axi_wstrb,
   input  logic                            s_axi_wvalid,
   output logic                            s_axi_wready,
   output logic [1:0]                      s_axi_bresp,
   output logic                            s_axi_bvalid,
   input  logic                            s_axi_bready,
   coef_if.regs                            coef
);

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   conv1_pkg::axi_wr_state_e state;

   conv1_pkg::coef_t weight_q [0:`CONV1_CHANNELS-1][0:`CONV1_TAPS-1];
   conv1_pkg::bias_t bias_q;

   logic [`CONV1_AXI_ADDR_BITS-3:0] word_idx;
   logic       accept;
   logic       wr_weight;
   logic       wr_bias;
   logic [1:0] wr_ch;
   logic [4:0] wr_tap;
   logic [1:0] wr_slot;

   assign word_idx = s_axi_awaddr[`CONV1_AXI_ADDR_BITS-1:2];   // byte address to word

   // both beats taken in the same cycle
   assign accept        = (state == conv1_pkg::WR_IDLE) && s_axi_awvalid && s_axi_wvalid;
   assign s_axi_awready = accept;
   assign s_axi_wready  = accept;
   assign s_axi_bvalid  = (state == conv1_pkg::WR_RESP);

   // word index to channel and tap, or bias slot
   always_comb begin
      wr_weight = 1'b0;
      wr_bias   = 1'b0;
      wr_ch     = 2'd0;
      wr_tap    = 5'd0;
      wr_slot   = 2'd0;
      if (word_idx < `CONV1_TAPS) begin
         wr_weight = 1'b1;
         wr_tap    = 5'(word_idx);
      end else if (word_idx < 2 * `CONV1_TAPS) begin
         wr_weight = 1'b1;
         wr_ch     = 2'd1;
         wr_tap    = 5'(word_idx - `CONV1_TAPS);
      end else if (word_idx < 3 * `CONV1_TAPS) begin
         wr_weight = 1'b1;
         wr_ch     = 2'd2;
         wr_tap    = 5'(word_idx - 2 * `CONV1_TAPS);
      end else if (word_idx >= `CONV1_BIAS_BASE &&
                   word_idx < `CONV1_BIAS_BASE + `CONV1_CHANNELS) begin
         wr_bias = 1'b1;
         wr_slot = 2'(word_idx - `CONV1_BIAS_BASE);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state       <= conv1_pkg::WR_IDLE;
         s_axi_bresp <= RESP_OKAY;
      end else begin
         case (state)
            conv1_pkg::WR_IDLE: begin
               if (accept) begin
                  state       <= conv1_pkg::WR_RESP;
                  s_axi_bresp <= (wr_weight || wr_bias) ? RESP_OKAY : RESP_SLVERR;
               end
            end
            conv1_pkg::WR_RESP: begin
               if (s_axi_bready)
                  state <= conv1_pkg::WR_IDLE;   // response taken
            end
            default: state <= conv1_pkg::WR_IDLE;
         endcase
      end
   end

   // coefficient storage, low byte only
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int ch = 0; ch < `CONV1_CHANNELS; ch++) begin
            for (int t = 0; t < `CONV1_TAPS; t++)
               weight_q[ch][t] <= '0;
            bias_q[ch] <= '0;
         end
      end else if (accept && s_axi_wstrb[0]) begin
         if (wr_weight)
            weight_q[wr_ch][wr_tap] <= s_axi_wdata[`CONV1_COEF_BITS-1:0];
         if (wr_bias)
            bias_q[wr_slot] <= s_axi_wdata[`CONV1_COEF_BITS-1:0];
      end
   end

   assign coef.kernel_0 = weight_q[0];
   assign coef.kernel_1 = weight_q[1];
   assign coef.kernel_2 = weight_q[2];
   assign coef.bias     = bias_q;

endmodule

`default_nettype wire

// File: hdl/line_buffer.sv
`timescale 1ns/100ps
`include "conv1_macros.svh"
`default_nettype none

module line_buffer (
   input  logic                clk,
   input  logic                rst_n,
   input  conv1_pkg::pixel_t   pixel,
   input  logic                pixel_valid,
   output conv1_pkg::window_t  window,
   output logic                window_valid
);

   localparam int FS       = `CONV1_FILTER_SIZE;
   localparam int ROWS_MEM = `CONV1_FILTER_SIZE - 1;   // previous rows kept

   conv1_pkg::fill_state_e state;

   logic [4:0] col;   // column of the pixel being accepted
   logic [4:0] row;

   logic last_col;
   logic last_row;

   // each row memory is a one-row delay line addressed by column
   conv1_pkg::pixel_t row_mem [0:ROWS_MEM-1][0:`CONV1_IMG_WIDTH-1];

   // new window column, index 0 is the oldest row
   conv1_pkg::pixel_t col_pix [0:FS-1];

   assign last_col = (col == 5'(`CONV1_IMG_WIDTH - 1));
   assign last_row = (row == 5'(`CONV1_IMG_HEIGHT - 1));

   always_comb begin
      for (int k = 0; k < ROWS_MEM; k++)
         col_pix[k] = row_mem[k][col];
      col_pix[FS-1] = pixel;   // current row
   end

   // position tracking and fill state
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= conv1_pkg::FILL_ROWS;
         col   <= '0;
         row   <= '0;
      end else if (pixel_valid) begin
         if (last_col) begin
            col <= '0;
            if (last_row) begin
               row   <= '0;
               state <= conv1_pkg::FILL_ROWS;   // next frame
            end else begin
               row <= row + 5'd1;
               if (row == 5'(FS - 2))
                  state <= conv1_pkg::SLIDE;    // row 4 starts next
            end
         end else begin
            col <= col + 5'd1;
         end
      end
   end

   // row memories push one row down per accepted pixel
   always_ff @(posedge clk) begin
      if (pixel_valid) begin
         for (int k = 0; k < ROWS_MEM; k++)
            row_mem[k][col] <= col_pix[k+1];
      end
   end

   // 5x5 window shifts left, new column enters on the right
   always_ff @(posedge clk) begin
      if (pixel_valid) begin
         for (int r = 0; r < FS; r++) begin
            for (int c = 0; c < FS - 1; c++)
               window[r*FS + c] <= window[r*FS + c + 1];
            window[r*FS + FS - 1] <= col_pix[r];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         window_valid <= 1'b0;
      else
         window_valid <= pixel_valid && (state == conv1_pkg::SLIDE) &&
                         (col >= 5'(FS - 1));   // full window only
   end

endmodule

`default_nettype wire

// File: hdl/conv_mac.sv
`timescale 1ns/100ps
`include "conv1_macros.svh"
`default_nettype none

module conv_mac (
   input  logic                clk,
   input  logic                rst_n,
   input  conv1_pkg::window_t  window,
   input  logic                window_valid,
   coef_if.mac                 coef,
   output conv1_pkg::conv_t    conv_out_0,
   output conv1_pkg::conv_t    conv_out_1,
   output conv1_pkg::conv_t    conv_out_2,
   output logic                conv_valid
);

   // dot product of one kernel, then scale and bias
   function automatic conv1_pkg::conv_t channel_result(
      input conv1_pkg::window_t win,
      input conv1_pkg::kernel_t kern,
      input conv1_pkg::coef_t   bias
   );
      conv1_pkg::acc_t  acc;
      conv1_pkg::conv_t scaled;
      logic signed [`CONV1_PIXEL_BITS:0] px;
      acc = '0;
      for (int t = 0; t < `CONV1_TAPS; t++) begin
         px  = $signed({1'b0, win[t]});   // pixel stays positive
         acc = acc + px * kern[t];        // wraps at 20 bits
      end
      scaled = acc[`CONV1_FRAC_SHIFT +: `CONV1_OUT_BITS];
      return scaled + conv1_pkg::conv_t'(bias);
   endfunction

   conv1_pkg::conv_t res_0;
   conv1_pkg::conv_t res_1;
   conv1_pkg::conv_t res_2;

   always_comb begin
      res_0 = channel_result(window, coef.kernel_0, coef.bias[0]);
      res_1 = channel_result(window, coef.kernel_1, coef.bias[1]);
      res_2 = channel_result(window, coef.kernel_2, coef.bias[2]);
   end

   // results held between windows
   always_ff @(posedge clk) begin
      if (window_valid) begin
         conv_out_0 <= res_0;
         conv_out_1 <= res_1;
         conv_out_2 <= res_2;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         conv_valid <= 1'b0;
      else
         conv_valid <= window_valid;   // one cycle behind the window
   end

endmodule

`default_nettype wire

// File: hdl/conv1_top.sv
`timescale 1ns/100ps
`include "conv1_macros.svh"
`default_nettype none

module conv1_top (
   input  logic                            clk,
   input  logic                            rst_n,
   // AXI4-Lite write channels
   input  logic [`CONV1_AXI_ADDR_BITS-1:0] s_axi_awaddr,
   input  logic                            s_axi_awvalid,
   output logic                            s_axi_awready,
   input  logic [31:0]                     s_axi_wdata,
   input  logic [3:0]                      s_axi_wstrb,
   input  logic                            s_axi_wvalid,
   output logic                            s_axi_wready,
   output logic [1:0]                      s_axi_bresp,
   output logic                            s_axi_bvalid,
   input  logic                            s_axi_bready,
   // pixel stream
   input  conv1_pkg::pixel_t               pixel,
   input  logic                            pixel_valid,
   // results
   output conv1_pkg::conv_t                conv_out_0,
   output conv1_pkg::conv_t                conv_out_1,
   output conv1_pkg::conv_t                conv_out_2,
   output logic                            conv_valid
);

   coef_if coef_bus ();

   conv1_pkg::window_t window;
   logic               window_valid;

   coef_regs u_coef_regs (
      .clk           (clk),
      .rst_n         (rst_n),
      .s_axi_awaddr  (s_axi_awaddr),
      .s_axi_awvalid (s_axi_awvalid),
      .s_axi_awready (s_axi_awready),
      .s_axi_wdata   (s_axi_wdata),
      .s_axi_wstrb   (s_axi_wstrb),
      .s_axi_wvalid  (s_axi_wvalid),
      .s_axi_wready  (s_axi_wready),
      .s_axi_bresp   (s_axi_bresp),
      .s_axi_bvalid  (s_axi_bvalid),
      .s_axi_bready  (s_axi_bready),
      .coef          (coef_bus.regs)
   );

   line_buffer u_line_buffer (
      .clk          (clk),
      .rst_n        (rst_n),
      .pixel        (pixel),
      .pixel_valid  (pixel_valid),
      .window       (window),
      .window_valid (window_valid)
   );

   conv_mac u_conv_mac (
      .clk          (clk),
      .rst_n        (rst_n),
      .window       (window),
      .window_valid (window_valid),
      .coef         (coef_bus.mac),
      .conv_out_0   (conv_out_0),
      .conv_out_1   (conv_out_1),
      .conv_out_2   (conv_out_2),
      .conv_valid   (conv_valid)
   );

endmodule

`default_nettype wire

// File: tests/conv1_assert.sv
`timescale 1ns/100ps
`default_nettype none

module conv1_assert (
   input logic clk,
   input logic rst_n,
   input logic conv_valid,
   input logic s_axi_awready,
   input logic s_axi_wready,
   input logic s_axi_bvalid,
   input logic s_axi_bready
);

   int fail_cnt = 0;   // read by the testbench at the end

   // first cycle out of reset
   reset_quiet: assert property (@(posedge clk)
      $rose(rst_n) |-> !conv_valid && !s_axi_bvalid && !s_axi_awready)
      else begin
         fail_cnt++;
         $error("outputs active in the first cycle after reset");
      end

   bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
      s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
      else begin
         fail_cnt++;
         $error("write response dropped before bready");
      end

   ready_pair: assert property (@(posedge clk) disable iff (!rst_n)
      s_axi_awready == s_axi_wready)
      else begin
         fail_cnt++;
         $error("awready and wready differ");
      end

endmodule

bind conv1_top conv1_assert u_conv1_assert (
   .clk           (clk),
   .rst_n         (rst_n),
   .conv_valid    (conv_valid),
   .s_axi_awready (s_axi_awready),
   .s_axi_wready  (s_axi_wready),
   .s_axi_bvalid  (s_axi_bvalid),
   .s_axi_bready  (s_axi_bready)
);

`default_nettype wire

// File: tests/tb_conv1.sv
`timescale 1ns/100ps
`include "conv1_macros.svh"
`default_nettype none

module tb_conv1;

   localparam int W = `CONV1_IMG_WIDTH;
   localparam int H = `CONV1_IMG_HEIGHT;
   localparam int PER_FRAME = (W - 4) * (H - 4);
   localparam int MAX_RES = 4 * PER_FRAME;
   localparam int N_WEIGHTS = `CONV1_CHANNELS * `CONV1_TAPS;
   // 4 frames, one with gaps averaging 1.5 cycles, and about 160 writes
   localparam int TIMEOUT_CYCLES = 8000;

   logic clk = 1'b0;
   logic rst_n;
   logic [`CONV1_AXI_ADDR_BITS-1:0] s_axi_awaddr;
   logic s_axi_awvalid;
   logic s_axi_awready;
   logic [31:0] s_axi_wdata;
   logic [3:0] s_axi_wstrb;
   logic s_axi_wvalid;
   logic s_axi_wready;
   logic [1:0] s_axi_bresp;
   logic s_axi_bvalid;
   logic s_axi_bready;
   conv1_pkg::pixel_t pixel;
   logic pixel_valid;
   conv1_pkg::conv_t conv_out_0;
   conv1_pkg::conv_t conv_out_1;
   conv1_pkg::conv_t conv_out_2;
   logic conv_valid;

   int seed = 32'h8c60;
   int errors = 0;
   int cycles = 0;
   int wr_idx = 0;   // expected results pushed
   int rd_idx = 0;   // results seen
   logic [1:0] exp_bresp = 2'b00;

   // reference copy of coefficients and the current frame
   logic signed [7:0] m_w [0:`CONV1_CHANNELS-1][0:`CONV1_TAPS-1];
   logic signed [7:0] m_b [0:`CONV1_CHANNELS-1];
   logic [7:0] img [0:H-1][0:W-1];
   conv1_pkg::conv_t exp_0 [0:MAX_RES-1];
   conv1_pkg::conv_t exp_1 [0:MAX_RES-1];
   conv1_pkg::conv_t exp_2 [0:MAX_RES-1];

   conv1_top DUT (.*);

   always #10 clk = ~clk;

   always @(posedge clk) begin
      if (rst_n && conv_valid)
         rd_idx <= rd_idx + 1;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("=== FAIL ===");
         $finish;
      end
   end

   chk_out_0: assert property (@(posedge clk) disable iff (!rst_n)
      conv_valid |-> conv_out_0 == exp_0[rd_idx])
      else begin
         errors++;
         $display("Fail at %0t: channel 0 result %0d is %0d", $time, $sampled(rd_idx),
                  $sampled(conv_out_0));
      end

   chk_out_1: assert property (@(posedge clk) disable iff (!rst_n)
      conv_valid |-> conv_out_1 == exp_1[rd_idx])
      else begin
         errors++;
         $display("Fail at %0t: channel 1 result %0d is %0d", $time, $sampled(rd_idx),
                  $sampled(conv_out_1));
      end

   chk_out_2: assert property (@(posedge clk) disable iff (!rst_n)
      conv_valid |-> conv_out_2 == exp_2[rd_idx])
      else begin
         errors++;
         $display("Fail at %0t: channel 2 result %0d is %0d", $time, $sampled(rd_idx),
                  $sampled(conv_out_2));
      end

   chk_extra: assert property (@(posedge clk) disable iff (!rst_n)
      conv_valid |-> rd_idx < wr_idx)
      else begin
         errors++;
         $display("more results arrived than window positions were sent (at %0t)", $time);
      end

   chk_bresp: assert property (@(posedge clk) disable iff (!rst_n)
      s_axi_bvalid && s_axi_bready |-> s_axi_bresp == exp_bresp)
      else begin
         errors++;
         $display("Fail at %0t: write response %0d, expected %0d", $time,
                  $sampled(s_axi_bresp), $sampled(exp_bresp));
      end

   // window sum, bits 19..8, then sign-extended bias with 12-bit wrap
   function automatic conv1_pkg::conv_t model_result(input int ch, input int r0, input int c0);
      int sum;
      int px;
      int wt;
      logic [19:0] acc;
      logic [11:0] res;
      sum = 0;
      for (int i = 0; i < 5; i++) begin
         for (int j = 0; j < 5; j++) begin
            px  = img[r0 + i][c0 + j];
            wt  = m_w[ch][i * 5 + j];
            sum = sum + px * wt;
         end
      end
      acc = sum[19:0];
      res = acc[19:8] + {{4{m_b[ch][7]}}, m_b[ch]};
      return res;
   endfunction

   task automatic axi_write(input int idx, input logic [7:0] data, input int hold);
      int upper;
      bit mapped;
      upper  = $random(seed);
      mapped = (idx < N_WEIGHTS) ||
               (idx >= `CONV1_BIAS_BASE && idx < `CONV1_BIAS_BASE + `CONV1_CHANNELS);
      if (mapped && idx < N_WEIGHTS)
         m_w[idx / `CONV1_TAPS][idx % `CONV1_TAPS] = data;
      else if (mapped)
         m_b[idx - `CONV1_BIAS_BASE] = data;
      @(posedge clk);
      exp_bresp     = mapped ? 2'b00 : 2'b10;   // OKAY or SLVERR
      s_axi_awaddr  <= 10'(idx * 4);
      s_axi_wdata   <= {upper[31:8], data};   // upper bytes ignored by the DUT
      s_axi_wstrb   <= 4'hf;
      s_axi_awvalid <= 1'b1;
      s_axi_wvalid  <= 1'b1;
      s_axi_bready  <= (hold == 0);
      do @(negedge clk); while (!s_axi_awready);
      @(posedge clk);
      s_axi_awvalid <= 1'b0;
      s_axi_wvalid  <= 1'b0;
      repeat (hold) @(posedge clk);
      s_axi_bready <= 1'b1;
      do @(negedge clk); while (!(s_axi_bvalid && s_axi_bready));
   endtask

   task automatic load_coefs(input bit negative);
      logic [7:0] v;
      for (int i = 0; i < `CONV1_BIAS_BASE + `CONV1_CHANNELS; i++) begin
         if (i >= N_WEIGHTS && i < `CONV1_BIAS_BASE)
            continue;
         v = 8'($random(seed));
         if (negative && (i >= `CONV1_BIAS_BASE || i % 2 == 0))
            v[7] = 1'b1;
         axi_write(i, v, (i == 0) ? 3 : 0);   // first write stalls bready
      end
   endtask

   task automatic send_frame(input bit gaps);
      int gap;
      logic [7:0] p;
      for (int r = 0; r < H; r++) begin
         for (int c = 0; c < W; c++) begin
            gap = gaps ? ($random(seed) & 3) : 0;
            repeat (gap) begin
               @(posedge clk);
               pixel_valid <= 1'b0;
            end
            p = 8'($random(seed));
            @(posedge clk);
            pixel       <= p;
            pixel_valid <= 1'b1;
            img[r][c] = p;
            if (r >= 4 && c >= 4) begin   // completes window at (r-4, c-4)
               exp_0[wr_idx] = model_result(0, r - 4, c - 4);
               exp_1[wr_idx] = model_result(1, r - 4, c - 4);
               exp_2[wr_idx] = model_result(2, r - 4, c - 4);
               wr_idx++;
            end
         end
      end
      @(posedge clk);
      pixel_valid <= 1'b0;
   endtask

   task automatic drain_results(input int total);
      while (rd_idx != wr_idx)
         @(posedge clk);
      repeat (4) @(posedge clk);   // room for stray results
      count_ok: assert (rd_idx == total)
         else begin
            errors++;
            $display("Fail at %0t: %0d results seen, %0d expected", $time, rd_idx, total);
         end
   endtask

   initial begin
      rst_n         = 1'b0;
      s_axi_awaddr  = '0;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = '0;
      s_axi_wstrb   = '0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b0;
      pixel         = '0;
      pixel_valid   = 1'b0;
      for (int ch = 0; ch < `CONV1_CHANNELS; ch++) begin
         for (int t = 0; t < `CONV1_TAPS; t++)
            m_w[ch][t] = '0;
         m_b[ch] = '0;
      end
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;

      axi_write(90, 8'h5a, 0);   // unmapped, coefficients stay zero
      send_frame(1'b0);
      drain_results(PER_FRAME);

      load_coefs(1'b0);
      send_frame(1'b0);
      drain_results(2 * PER_FRAME);
      send_frame(1'b1);          // pixel_valid gaps
      drain_results(3 * PER_FRAME);

      load_coefs(1'b1);          // negative biases and weights
      send_frame(1'b0);
      drain_results(4 * PER_FRAME);

      errors = errors + DUT.u_conv1_assert.fail_cnt;
      $display("errors: %0d, results: %0d of %0d", errors, rd_idx, MAX_RES);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// File: conv1.f
+incdir+hdl
hdl/conv1_pkg.sv
hdl/coef_if.sv
hdl/coef_regs.sv
hdl/line_buffer.sv
hdl/conv_mac.sv
hdl/conv1_top.sv
tests/conv1_assert.sv
tests/tb_conv1.sv

// File: Makefile
# Verilator build for the conv1 layer

VERILATOR ?= verilator
TOP       ?= tb_conv1
FILELIST  ?= conv1.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES   := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
